// File: files.f
src/sm83_pkg.sv
src/sm83_alu.sv
src/sm83_regfile.sv
src/sm83_decoder.sv
src/sm83_core.sv
tb/sm83_core_chk.sv
tb/sm83_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the SM83 core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

if ! verilator --binary --timing --assert \
        --top-module sm83_core_tb -Mdir "$build_dir" -o sm83_sim -f files.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$build_dir/sm83_sim" +verilator+error+limit+100 > "$log" 2>&1; then
    cat "$log"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$log"

if grep -qx "RESULT: PASS" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

// File: src/sm83_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_alu (
    input  sm83_pkg::alu_op_e           op,
    input  logic [sm83_pkg::DATA_W-1:0] a,
    input  logic [sm83_pkg::DATA_W-1:0] b,
    input  logic                        carry_in,
    output logic [sm83_pkg::DATA_W-1:0] result,
    output sm83_pkg::flags_t            flags_out
);
    import sm83_pkg::*;

    logic            cin;
    logic [4:0]      add_lo;
    logic [4:0]      sub_lo;
    logic [DATA_W:0] add_full;
    logic [DATA_W:0] sub_full;

    // Only ADC and SBC chain the carry in
    assign cin = (op == ALU_ADC || op == ALU_SBC) ? carry_in : 1'b0;

    // Bit 4 of the nibble sums is the half carry or half borrow
    assign add_lo   = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin};
    assign sub_lo   = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, cin};
    assign add_full = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, cin};
    assign sub_full = {1'b0, a} - {1'b0, b} - {{DATA_W{1'b0}}, cin};

    always_comb begin
        result      = a;
        flags_out   = '0;

        case (op)
            ALU_ADD, ALU_ADC, ALU_INC: begin
                result      = add_full[DATA_W-1:0];
                flags_out.h = add_lo[4];
                flags_out.c = add_full[DATA_W];
            end
            ALU_SUB, ALU_SBC, ALU_CP, ALU_DEC: begin
                // CP result is dropped by the decoder
                result      = sub_full[DATA_W-1:0];
                flags_out.n = 1'b1;
                flags_out.h = sub_lo[4];
                flags_out.c = sub_full[DATA_W];
            end
            ALU_AND: begin
                result      = a & b;
                flags_out.h = 1'b1;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_OR: begin
                result = a | b;
            end
            default: begin
                result = a;
            end
        endcase

        flags_out.z = (result == '0);
    end

endmodule

`default_nettype wire

// File: src/sm83_core.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [sm83_pkg::DATA_W-1:0] mem_rdata,
    output sm83_pkg::mem_req_t          mem_req
);
    import sm83_pkg::*;

    uop_t              uop;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] operand;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_result;
    flags_t            flags;
    flags_t            alu_flags;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // Accumulator ops take A, INC/DEC and moves work on the selected register
    assign alu_a = (uop.alu_op <= ALU_CP) ? acc : operand;
    assign alu_b = uop.alu_b_imm1 ? DATA_W'(1) : operand;

    sm83_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .uop       (uop)
    );

    sm83_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .uop        (uop),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .acc        (acc),
        .operand    (operand),
        .flags      (flags),
        .addr       (addr),
        .wdata      (wdata)
    );

    sm83_alu u_alu (
        .op        (uop.alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .carry_in  (flags.c),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    assign mem_req = '{op: uop.bus_op, addr: addr, wdata: wdata};

endmodule

`default_nettype wire

// File: src/sm83_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [sm83_pkg::DATA_W-1:0] mem_rdata,
    output sm83_pkg::uop_t              uop
);
    import sm83_pkg::*;

    opcode_u    ir;
    logic [1:0] m_cycle;

    reg8_e   src_reg;
    reg8_e   dst_reg;
    alu_op_e alu_y;
    alu_op_e step_op;

    assign src_reg = reg8_e'({1'b0, ir.xyz.z});
    assign dst_reg = reg8_e'({1'b0, ir.xyz.y});
    assign alu_y   = alu_op_e'({1'b0, ir.xyz.y});
    // INC has z=4, DEC has z=5
    assign step_op = ir.xyz.z[0] ? ALU_DEC : ALU_INC;

    always_comb begin
        // Default is the opcode fetch that closes every instruction
        uop          = '0;
        uop.bus_op   = BUS_FETCH;
        uop.addr_sel = ADDR_PC;
        uop.pc_inc   = 1'b1;
        uop.rd_sel   = R_A;
        uop.wr_sel   = R_A;
        uop.alu_op   = ALU_PASS;
        uop.pair_sel = RR_BC;

        case (ir.xyz.x)
            2'd0: begin
                if (ir.xpqz.z == 3'd1 && !ir.xpqz.q && ir.xpqz.p != 2'd3) begin
                    // LD rr,nn, low byte into Z then high byte into W
                    if (m_cycle != 2'd2) begin
                        uop.bus_op      = BUS_READ;
                        uop.wr_en       = 1'b1;
                        uop.wr_from_mem = 1'b1;
                        uop.wr_sel      = (m_cycle == 2'd0) ? R_Z : R_W;
                    end else begin
                        uop.wz_copy  = 1'b1;
                        uop.pair_sel = reg16_e'(ir.xpqz.p);
                    end
                end else if (ir.xyz.z == 3'd4 || ir.xyz.z == 3'd5) begin
                    uop.alu_op      = step_op;
                    uop.alu_b_imm1  = 1'b1;
                    uop.flag_keep_c = 1'b1;
                    if (dst_reg != R_HL_MEM) begin
                        uop.rd_sel   = dst_reg;
                        uop.wr_sel   = dst_reg;
                        uop.wr_en    = 1'b1;
                        uop.flags_we = 1'b1;
                    end else if (m_cycle == 2'd0) begin
                        uop.bus_op      = BUS_READ;
                        uop.addr_sel    = ADDR_HL;
                        uop.pc_inc      = 1'b0;
                        uop.wr_sel      = R_Z;
                        uop.wr_en       = 1'b1;
                        uop.wr_from_mem = 1'b1;
                    end else if (m_cycle == 2'd1) begin
                        // Z steps and goes out on the bus in the same cycle
                        uop.bus_op   = BUS_WRITE;
                        uop.addr_sel = ADDR_HL;
                        uop.pc_inc   = 1'b0;
                        uop.rd_sel   = R_Z;
                        uop.wr_sel   = R_Z;
                        uop.wr_en    = 1'b1;
                        uop.flags_we = 1'b1;
                    end
                end else if (ir.xyz.z == 3'd6) begin
                    if (m_cycle == 2'd0) begin
                        uop.bus_op      = BUS_READ;
                        uop.wr_en       = 1'b1;
                        uop.wr_from_mem = 1'b1;
                        uop.wr_sel      = (dst_reg == R_HL_MEM) ? R_Z : dst_reg;
                    end else if (m_cycle == 2'd1 && dst_reg == R_HL_MEM) begin
                        uop.bus_op   = BUS_WRITE;
                        uop.addr_sel = ADDR_HL;
                        uop.pc_inc   = 1'b0;
                        uop.rd_sel   = R_Z;
                    end
                end
            end

            2'd1: begin
                // 0x76 matches none of these and runs as a NOP
                if (src_reg == R_HL_MEM && dst_reg != R_HL_MEM) begin
                    if (m_cycle == 2'd0) begin
                        uop.bus_op      = BUS_READ;
                        uop.addr_sel    = ADDR_HL;
                        uop.pc_inc      = 1'b0;
                        uop.wr_sel      = dst_reg;
                        uop.wr_en       = 1'b1;
                        uop.wr_from_mem = 1'b1;
                    end
                end else if (dst_reg == R_HL_MEM && src_reg != R_HL_MEM) begin
                    if (m_cycle == 2'd0) begin
                        uop.bus_op   = BUS_WRITE;
                        uop.addr_sel = ADDR_HL;
                        uop.pc_inc   = 1'b0;
                        uop.rd_sel   = src_reg;
                    end
                end else if (src_reg != R_HL_MEM) begin
                    uop.rd_sel = src_reg;
                    uop.wr_sel = dst_reg;
                    uop.wr_en  = 1'b1;
                end
            end

            default: begin
                // ALU on register, [HL] (x=2) or immediate (x=3)
                if (ir.xyz.x == 2'd2 || ir.xyz.z == 3'd6) begin
                    if (ir.xyz.z == 3'd6 && m_cycle == 2'd0) begin
                        uop.bus_op      = BUS_READ;
                        uop.wr_sel      = R_Z;
                        uop.wr_en       = 1'b1;
                        uop.wr_from_mem = 1'b1;
                        if (ir.xyz.x == 2'd2) begin
                            uop.addr_sel = ADDR_HL;
                            uop.pc_inc   = 1'b0;
                        end
                    end else begin
                        uop.rd_sel   = (ir.xyz.z == 3'd6) ? R_Z : src_reg;
                        uop.alu_op   = alu_y;
                        uop.wr_sel   = R_A;
                        // CP only sets flags
                        uop.wr_en    = (alu_y != ALU_CP);
                        uop.flags_we = 1'b1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir      <= OPCODE_NOP;
            m_cycle <= 2'd0;
        end else if (uop.bus_op == BUS_FETCH) begin
            ir      <= mem_rdata;
            m_cycle <= 2'd0;
        end else begin
            m_cycle <= m_cycle + 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: src/sm83_pkg.sv
`default_nettype none

package sm83_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // Instruction register value while in reset
    localparam logic [DATA_W-1:0] OPCODE_NOP = 8'h00;

    // Opcode register order, code 6 stands for [HL]
    typedef enum logic [3:0] {
        R_B      = 4'd0,
        R_C      = 4'd1,
        R_D      = 4'd2,
        R_E      = 4'd3,
        R_H      = 4'd4,
        R_L      = 4'd5,
        R_HL_MEM = 4'd6,
        R_A      = 4'd7,
        R_Z      = 4'd8,
        R_W      = 4'd9
    } reg8_e;

    typedef enum logic [1:0] {
        RR_BC   = 2'd0,
        RR_DE   = 2'd1,
        RR_HL   = 2'd2,
        RR_NONE = 2'd3
    } reg16_e;

    // First eight follow the y field of the ALU opcodes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADC  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SBC  = 4'd3,
        ALU_AND  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_CP   = 4'd7,
        ALU_INC  = 4'd8,
        ALU_DEC  = 4'd9,
        ALU_PASS = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        BUS_IDLE  = 2'd0,
        BUS_FETCH = 2'd1,
        BUS_READ  = 2'd2,
        BUS_WRITE = 2'd3
    } bus_op_e;

    typedef enum logic [1:0] {
        ADDR_PC   = 2'd0,
        ADDR_HL   = 2'd1,
        ADDR_PAIR = 2'd2
    } addr_sel_e;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    // Same opcode byte, two field splits
    typedef union packed {
        struct packed {
            logic [1:0] x;
            logic [2:0] y;
            logic [2:0] z;
        } xyz;
        struct packed {
            logic [1:0] x;
            logic [1:0] p;
            logic       q;
            logic [2:0] z;
        } xpqz;
    } opcode_u;

    typedef struct packed {
        bus_op_e   bus_op;
        addr_sel_e addr_sel;
        logic      pc_inc;
        logic      hl_inc;
        reg8_e     rd_sel;
        reg8_e     wr_sel;
        logic      wr_en;
        logic      wr_from_mem;
        alu_op_e   alu_op;
        logic      alu_b_imm1;
        logic      flags_we;
        logic      flag_keep_c;
        logic      wz_copy;
        reg16_e    pair_sel;
    } uop_t;

    typedef struct packed {
        bus_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: src/sm83_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_regfile (
    input  logic                        clk,
    input  logic                        rst,
    input  sm83_pkg::uop_t              uop,
    input  logic [sm83_pkg::DATA_W-1:0] mem_rdata,
    input  logic [sm83_pkg::DATA_W-1:0] alu_result,
    input  sm83_pkg::flags_t            alu_flags,
    output logic [sm83_pkg::DATA_W-1:0] acc,
    output logic [sm83_pkg::DATA_W-1:0] operand,
    output sm83_pkg::flags_t            flags,
    output logic [sm83_pkg::ADDR_W-1:0] addr,
    output logic [sm83_pkg::DATA_W-1:0] wdata
);
    import sm83_pkg::*;

    logic [DATA_W-1:0] reg_b, reg_c, reg_d, reg_e;
    logic [DATA_W-1:0] reg_h, reg_l, reg_a;
    // Temporaries for immediates and memory operands
    logic [DATA_W-1:0] reg_z, reg_w;
    logic [ADDR_W-1:0] pc;

    logic [ADDR_W-1:0] pair_val;
    logic [ADDR_W-1:0] addr_inc;
    logic [DATA_W-1:0] wr_val;

    always_comb begin
        case (uop.rd_sel)
            R_B:     operand = reg_b;
            R_C:     operand = reg_c;
            R_D:     operand = reg_d;
            R_E:     operand = reg_e;
            R_H:     operand = reg_h;
            R_L:     operand = reg_l;
            R_A:     operand = reg_a;
            R_Z:     operand = reg_z;
            R_W:     operand = reg_w;
            default: operand = '0;
        endcase
    end

    always_comb begin
        case (uop.pair_sel)
            RR_BC:   pair_val = {reg_b, reg_c};
            RR_DE:   pair_val = {reg_d, reg_e};
            RR_HL:   pair_val = {reg_h, reg_l};
            default: pair_val = '0;
        endcase
    end

    always_comb begin
        case (uop.addr_sel)
            ADDR_HL:   addr = {reg_h, reg_l};
            ADDR_PAIR: addr = pair_val;
            default:   addr = pc;
        endcase
    end

    // Single incrementer shared by PC and HL
    assign addr_inc = addr + ADDR_W'(1);

    assign wr_val = uop.wr_from_mem ? mem_rdata : alu_result;
    // A register written this cycle goes out with its new value
    assign wdata  = uop.wr_en ? wr_val : operand;
    assign acc    = reg_a;

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_b <= '0;
            reg_c <= '0;
            reg_d <= '0;
            reg_e <= '0;
            reg_h <= '0;
            reg_l <= '0;
            reg_a <= '0;
            reg_z <= '0;
            reg_w <= '0;
            pc    <= '0;
            flags <= '0;
        end else begin
            if (uop.wr_en) begin
                case (uop.wr_sel)
                    R_B:     reg_b <= wr_val;
                    R_C:     reg_c <= wr_val;
                    R_D:     reg_d <= wr_val;
                    R_E:     reg_e <= wr_val;
                    R_H:     reg_h <= wr_val;
                    R_L:     reg_l <= wr_val;
                    R_A:     reg_a <= wr_val;
                    R_Z:     reg_z <= wr_val;
                    R_W:     reg_w <= wr_val;
                    default: ;
                endcase
            end
            if (uop.flags_we) begin
                flags.z <= alu_flags.z;
                flags.n <= alu_flags.n;
                flags.h <= alu_flags.h;
                flags.c <= uop.flag_keep_c ? flags.c : alu_flags.c;
            end
            if (uop.wz_copy) begin
                case (uop.pair_sel)
                    RR_BC:   {reg_b, reg_c} <= {reg_w, reg_z};
                    RR_DE:   {reg_d, reg_e} <= {reg_w, reg_z};
                    RR_HL:   {reg_h, reg_l} <= {reg_w, reg_z};
                    default: ;
                endcase
            end
            if (uop.pc_inc) begin
                pc <= addr_inc;
            end
            if (uop.hl_inc) begin
                {reg_h, reg_l} <= addr_inc;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/sm83_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_core_chk (
    input logic               clk,
    input logic               rst,
    input sm83_pkg::mem_req_t mem_req
);
    import sm83_pkg::*;

    int rst_write_fails = 0;
    int start_fails = 0;
    int double_write_fails = 0;
    int fail_count;

    assign fail_count = rst_write_fails + start_fails + double_write_fails;

    no_write_in_reset: assert property (@(posedge clk) rst |-> mem_req.op != BUS_WRITE)
        else begin
            $error("WRITE issued while rst is high");
            rst_write_fails++;
        end

    // First cycle out of reset fetches the opcode at 0x0000
    fetch_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (mem_req.op == BUS_FETCH && mem_req.addr == 16'h0000))
        else begin
            $error("first cycle after reset is not a FETCH at 0x0000");
            start_fails++;
        end

    no_back_to_back_write: assert property (@(posedge clk) disable iff (rst)
        mem_req.op == BUS_WRITE |=> mem_req.op != BUS_WRITE)
        else begin
            $error("WRITE in two consecutive cycles");
            double_write_fails++;
        end

endmodule

bind sm83_core sm83_core_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req)
);

`default_nettype wire

// File: tb/sm83_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_core_tb;
    import sm83_pkg::*;

    // Program bytes right aligned, first byte most significant
    typedef struct packed {
        logic [127:0]      prog;
        int                len;
        int                n_writes;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } test_row_t;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic [DATA_W-1:0] mem_rdata;
    mem_req_t          mem_req;

    // 64 KB memory, zero bytes run as NOP
    bit   [DATA_W-1:0] mem [0:65535];
    logic              load_prog = 1'b0;
    logic [127:0]      cur_prog = '0;
    int                cur_len = 0;

    test_row_t tests[$];
    int        cycle_count = 0;
    int        cycle_limit = 0;
    int        pass_count = 0;
    int        fail_count = 0;

    sm83_core u_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req)
    );

    always #5 clk = ~clk;

    assign mem_rdata = mem[mem_req.addr];

    function automatic logic [7:0] prog_byte(input logic [127:0] prog, input int len,
                                             input int idx);
        logic [127:0] shifted;
        shifted = prog >> (8 * (len - 1 - idx));
        return shifted[7:0];
    endfunction

    always @(posedge clk) begin
        if (load_prog) begin
            for (int a = 0; a < 65536; a++) begin
                mem[16'(a)] <= '0;
            end
            for (int i = 0; i < 16; i++) begin
                if (i < cur_len) begin
                    mem[16'(i)] <= prog_byte(cur_prog, cur_len, i);
                end
            end
        end else if (mem_req.op == BUS_WRITE) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // Watchdog on cycles out of reset
    always @(posedge clk) begin
        if (!rst) begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_write(input mem_req_t actual, input mem_req_t expected,
                               output logic ok);
        ok = (actual.addr === expected.addr) && (actual.wdata === expected.wdata);
        if (!ok) begin
            $display("Error mem_req.addr/wdata: expected %h/%h, got %h/%h",
                     expected.addr, expected.wdata, actual.addr, actual.wdata);
        end
    endtask

    initial begin
        mem_req_t actual;
        mem_req_t expected;
        int       waited;
        int       writes;
        int       total_len;
        int       assert_fails;
        logic     ok;

        // Register chain B C D E L into A, stored at HL from LD HL,nn
        tests.push_back('{prog: 128'h065A_4851_5A6B_7D21_3412_77, len: 11,
                          n_writes: 1, addr: 16'h1234, data: 8'h5A});
        // ADD SUB AND XOR OR on immediates, then CP leaves A alone
        tests.push_back('{prog: 128'hC63C_D60F_E6F7_EE5A_F680_FEFF_2E40_77, len: 15,
                          n_writes: 1, addr: 16'h0040, data: 8'hFF});
        // ADC and SBC after carry out, INC H keeps carry for ADC
        tests.push_back('{prog: 128'h3EF0_C620_CE01_C6F0_DE01_D602_24CE_1077, len: 16,
                          n_writes: 1, addr: 16'h0100, data: 8'h0F});
        // Data byte 0x21 at 0x000F, result 3*0x21+1 after INC [HL]
        tests.push_back('{prog: 128'h2E0F_4686_804F_347E_812E_2077_0000_0021, len: 16,
                          n_writes: 2, addr: 16'h0020, data: 8'h64});
        // RLCA and DAA run as NOP
        tests.push_back('{prog: 128'h3E42_0727_2E30_0777, len: 8,
                          n_writes: 1, addr: 16'h0030, data: 8'h42});
        tests.push_back('{prog: 128'h1100_D001_00B0_2100_A036_99, len: 11,
                          n_writes: 1, addr: 16'hA000, data: 8'h99});

        total_len = 0;
        foreach (tests[t]) begin
            total_len += tests[t].len;
        end
        cycle_limit = 3 * total_len + 50;

        foreach (tests[t]) begin
            @(posedge clk);
            #1;
            rst       = 1'b1;
            cur_prog  = tests[t].prog;
            cur_len   = tests[t].len;
            load_prog = 1'b1;
            @(posedge clk);
            #1;
            load_prog = 1'b0;
            repeat (3) @(posedge clk);
            #1;
            rst = 1'b0;

            waited = 0;
            writes = 0;
            while (writes < tests[t].n_writes && waited < 3 * cur_len + 8) begin
                @(negedge clk);
                waited++;
                if (mem_req.op == BUS_WRITE) begin
                    writes++;
                    actual = mem_req;
                end
            end

            if (writes < tests[t].n_writes) begin
                $display("Test %0d failed: saw %0d of %0d writes within %0d cycles",
                         t, writes, tests[t].n_writes, waited);
                fail_count++;
            end else begin
                expected = '{op: BUS_WRITE, addr: tests[t].addr, wdata: tests[t].data};
                check_write(actual, expected, ok);
                if (ok) begin
                    $display("Test %0d passed: %h written at %h", t, actual.wdata, actual.addr);
                    pass_count++;
                end else begin
                    $display("Test %0d failed", t);
                    fail_count++;
                end
            end
        end

        assert_fails = u_dut.u_chk.fail_count;
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests.size(), pass_count, fail_count, assert_fails);
        if (fail_count == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
